// File: rtl/mem_pkg.sv
`default_nettype none

// Memory geometry and command encoding.
package mem_pkg;

    localparam int ADDR_W    = 9;
    localparam int DATA_W    = 32;
    localparam int MEM_DEPTH = 512;   // Addresses wrap modulo this.

    // Command opcodes.
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_FILL  = 2'd2,
        OP_SUM   = 2'd3
    } opcode_t;

endpackage

`default_nettype wire

// File: rtl/flow_pkg.sv
`default_nettype none

// Credit depths for the command and response ports.
package flow_pkg;

    localparam int CMD_CREDITS = 4;   // Equals fifo depth.
    localparam int RSP_CREDITS = 2;

    localparam int CMD_CNT_W = 3;     // Fifo occupancy, 0..4.
    localparam int RSP_CNT_W = 2;     // Response credits, 0..2.

endpackage

`default_nettype wire

// File: rtl/sram512x32.sv
`default_nettype none

module sram512x32
    import mem_pkg::*;
(
    input  logic              CK,
    input  logic              CS,
    input  logic              WE,
    input  logic [ADDR_W-1:0] A,
    input  logic [DATA_W-1:0] DI,
    output logic [DATA_W-1:0] DO
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [DATA_W-1:0] rd_word;

    assign rd_word = CS ? mem[A] : 'x;   // Unselected reads are undefined.

    always_ff @(posedge CK) begin
        if (CS && WE) begin
            mem[A] <= DI;
        end
    end

    // Registered read, sees the old word on a same-cycle write.
    always_ff @(posedge CK) begin
        DO <= rd_word;
    end

endmodule

`default_nettype wire

// File: rtl/cmd_fifo.sv
`default_nettype none

module cmd_fifo
    import mem_pkg::*;
    import flow_pkg::*;
(
    input  logic              CK,
    input  logic              rst,
    input  logic              cmd_valid,
    input  opcode_t           cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [ADDR_W-1:0] cmd_count,
    input  logic [DATA_W-1:0] cmd_data,
    input  logic              pop,
    output logic              head_valid,
    output opcode_t           head_op,
    output logic [ADDR_W-1:0] head_addr,
    output logic [ADDR_W-1:0] head_count,
    output logic [DATA_W-1:0] head_data,
    output logic              cmd_credit
);

    opcode_t           q_op    [CMD_CREDITS];
    logic [ADDR_W-1:0] q_addr  [CMD_CREDITS];
    logic [ADDR_W-1:0] q_count [CMD_CREDITS];
    logic [DATA_W-1:0] q_data  [CMD_CREDITS];

    logic [CMD_CNT_W-2:0] wr_ptr;   // Wraps at the depth.
    logic [CMD_CNT_W-2:0] rd_ptr;
    logic [CMD_CNT_W-1:0] used;

    // Host credits make overflow impossible.
    always_ff @(posedge CK) begin
        if (cmd_valid) begin
            q_op[wr_ptr]    <= cmd_op;
            q_addr[wr_ptr]  <= cmd_addr;
            q_count[wr_ptr] <= cmd_count;
            q_data[wr_ptr]  <= cmd_data;
        end
    end

    always_ff @(posedge CK) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            used       <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            cmd_credit <= pop;   // One credit back per entry popped.
            case ({cmd_valid, pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    assign head_valid = (used != '0);
    assign head_op    = q_op[rd_ptr];
    assign head_addr  = q_addr[rd_ptr];
    assign head_count = q_count[rd_ptr];
    assign head_data  = q_data[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/burst_gen.sv
`default_nettype none

module burst_gen
    import mem_pkg::*;
(
    input  logic              CK,
    input  logic              rst,
    input  logic              load,
    input  logic              step,
    input  logic [ADDR_W-1:0] head_addr,
    input  logic [ADDR_W-1:0] head_count,
    input  logic [DATA_W-1:0] head_data,
    output logic [ADDR_W-1:0] A,
    output logic [DATA_W-1:0] DI,
    output logic              last
);

    logic [ADDR_W-1:0] remain;   // Words left after the current one.

    always_ff @(posedge CK) begin
        if (rst) begin
            A      <= '0;
            remain <= '0;
        end else if (load) begin
            A      <= head_addr;
            remain <= head_count;
        end else if (step) begin
            A      <= A + 1'b1;   // Wraps past the top word.
            remain <= remain - 1'b1;
        end
    end

    always_ff @(posedge CK) begin
        if (load) DI <= head_data;
    end

    assign last = (remain == '0);

endmodule

`default_nettype wire

// File: rtl/read_accum.sv
`default_nettype none

module read_accum
    import mem_pkg::*;
(
    input  logic              CK,
    input  logic              rst,
    input  logic              rd_issue,
    input  logic              rd_accum,
    input  logic              rd_last,
    input  logic [DATA_W-1:0] DO,
    output logic              rsp_valid,
    output logic [DATA_W-1:0] rsp_data
);

    logic              issue_q;
    logic              accum_q;
    logic              last_q;
    logic [DATA_W-1:0] total;
    logic [DATA_W-1:0] total_next;

    // Tags line up with DO one cycle after the access.
    always_ff @(posedge CK) begin
        if (rst) begin
            issue_q <= 1'b0;
            accum_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            issue_q <= rd_issue;
            accum_q <= rd_accum;
            last_q  <= rd_last;
        end
    end

    assign total_next = total + DO;   // Wraps on overflow.

    always_ff @(posedge CK) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            total     <= '0;
        end else begin
            rsp_valid <= issue_q && (!accum_q || last_q);
            if (issue_q && accum_q) begin
                total <= last_q ? '0 : total_next;
            end
        end
    end

    always_ff @(posedge CK) begin
        if (issue_q && !accum_q) rsp_data <= DO;
        else if (issue_q && last_q) rsp_data <= total_next;
    end

endmodule

`default_nettype wire

// File: rtl/mem_ctrl.sv
`default_nettype none

module mem_ctrl
    import mem_pkg::*;
    import flow_pkg::*;
(
    input  logic              CK,
    input  logic              rst,
    input  logic              head_valid,
    input  opcode_t           head_op,
    input  logic [ADDR_W-1:0] head_count,
    input  logic              last,
    input  logic              rsp_credit,
    output logic              pop,
    output logic              load,
    output logic              step,
    output logic              CS,
    output logic              WE,
    output logic              rd_issue,
    output logic              rd_accum,
    output logic              rd_last
);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t               state;
    opcode_t              op;
    logic                 one_word;   // Burst ends after the first access.
    logic [RSP_CNT_W-1:0] credits;
    logic                 final_acc;
    logic                 needs_credit;
    logic                 go;
    logic                 spend;

    assign final_acc    = one_word || last;
    assign needs_credit = (op == OP_READ) || ((op == OP_SUM) && final_acc);
    assign go           = (state == RUN) && !(needs_credit && (credits == '0));

    assign pop  = (state == IDLE) && head_valid;
    assign load = pop;
    assign step = go;
    assign CS   = go;
    assign WE   = go && ((op == OP_WRITE) || (op == OP_FILL));

    // Read tags for the response former.
    assign rd_issue = go && ((op == OP_READ) || (op == OP_SUM));
    assign rd_accum = (op == OP_SUM);
    assign rd_last  = final_acc;

    assign spend = rd_issue && final_acc;   // Read that completes a response.

    always_ff @(posedge CK) begin
        if (rst) begin
            state    <= IDLE;
            op       <= OP_WRITE;
            one_word <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state    <= RUN;
                        op       <= head_op;
                        one_word <= (head_op == OP_READ) || (head_op == OP_WRITE) ||
                                    (head_count == '0);
                    end
                end
                RUN: begin
                    if (go && final_acc) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Response credit counter.
    always_ff @(posedge CK) begin
        if (rst) begin
            credits <= RSP_CNT_W'(RSP_CREDITS);
        end else if (rsp_credit && !spend) begin
            credits <= credits + 1'b1;
        end else if (!rsp_credit && spend) begin
            credits <= credits - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_engine_top.sv
`default_nettype none

module mem_engine_top
    import mem_pkg::*;
(
    input  logic              CK,
    input  logic              rst,
    input  logic              cmd_valid,
    input  opcode_t           cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [ADDR_W-1:0] cmd_count,
    input  logic [DATA_W-1:0] cmd_data,
    input  logic              rsp_credit,
    output logic              cmd_credit,
    output logic              rsp_valid,
    output logic [DATA_W-1:0] rsp_data
);

    logic              head_valid;
    opcode_t           head_op;
    logic [ADDR_W-1:0] head_addr;
    logic [ADDR_W-1:0] head_count;
    logic [DATA_W-1:0] head_data;
    logic              pop;
    logic              load;
    logic              step;
    logic              last;
    logic              cs;
    logic              we;
    logic              rd_issue;
    logic              rd_accum;
    logic              rd_last;
    logic [ADDR_W-1:0] sram_a;
    logic [DATA_W-1:0] sram_di;
    logic [DATA_W-1:0] sram_do;

    cmd_fifo i_cmd_fifo (
        .CK(CK), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
        .cmd_count(cmd_count), .cmd_data(cmd_data), .pop(pop),
        .head_valid(head_valid), .head_op(head_op), .head_addr(head_addr),
        .head_count(head_count), .head_data(head_data), .cmd_credit(cmd_credit)
    );

    mem_ctrl i_mem_ctrl (
        .CK(CK), .rst(rst),
        .head_valid(head_valid), .head_op(head_op), .head_count(head_count),
        .last(last), .rsp_credit(rsp_credit),
        .pop(pop), .load(load), .step(step), .CS(cs), .WE(we),
        .rd_issue(rd_issue), .rd_accum(rd_accum), .rd_last(rd_last)
    );

    burst_gen i_burst_gen (
        .CK(CK), .rst(rst), .load(load), .step(step),
        .head_addr(head_addr), .head_count(head_count), .head_data(head_data),
        .A(sram_a), .DI(sram_di), .last(last)
    );

    sram512x32 i_sram (
        .CK(CK), .CS(cs), .WE(we), .A(sram_a), .DI(sram_di), .DO(sram_do)
    );

    read_accum i_read_accum (
        .CK(CK), .rst(rst),
        .rd_issue(rd_issue), .rd_accum(rd_accum), .rd_last(rd_last), .DO(sram_do),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data)
    );

endmodule

`default_nettype wire

// File: sim/tb_mem_engine.sv
`default_nettype none

module tb_mem_engine
    import mem_pkg::*;
    import flow_pkg::*;
;

    localparam int MAX_CYCLES = 4000;   // Tests need about 1500.

    logic              CK;
    logic              rst;
    logic              cmd_valid;
    opcode_t           cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [ADDR_W-1:0] cmd_count;
    logic [DATA_W-1:0] cmd_data;
    logic              rsp_credit;
    logic              cmd_credit;
    logic              rsp_valid;
    logic [DATA_W-1:0] rsp_data;

    logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] exp_word;
    int errors       = 0;
    int cycles       = 0;
    int host_credits = CMD_CREDITS;
    int cmds_sent    = 0;
    int credits_back = 0;
    int rsp_count    = 0;
    int pending      = 0;   // Responses not yet credited back.
    logic hold_rsp   = 1'b0;

    mem_engine_top i_dut (
        .CK(CK), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
        .cmd_count(cmd_count), .cmd_data(cmd_data), .rsp_credit(rsp_credit),
        .cmd_credit(cmd_credit), .rsp_valid(rsp_valid), .rsp_data(rsp_data)
    );

    initial begin
        CK = 1'b0;
        forever #10 CK = ~CK;
    end

    always @(posedge CK) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d errors", cycles, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Consumer returns one credit per response unless held back.
    always @(posedge CK) begin
        #2;
        if (!rst && !hold_rsp && pending > 0) begin
            rsp_credit = 1'b1;
            pending = pending - 1;
        end else begin
            rsp_credit = 1'b0;
        end
    end

    // Outputs sampled mid-cycle.
    always @(negedge CK) begin
        if (cmd_credit === 1'b1) begin
            host_credits = host_credits + 1;
            credits_back = credits_back + 1;
            if (credits_back > cmds_sent) begin
                errors = errors + 1;
                $display("More cmd_credit pulses (%0d) than commands sent (%0d)",
                         credits_back, cmds_sent);
            end
        end
        if (rsp_valid === 1'b1) begin
            rsp_count = rsp_count + 1;
            pending = pending + 1;
            if (exp_q.size() == 0) begin
                errors = errors + 1;
                $display("Response arrived with none expected");
            end else begin
                exp_word = exp_q.pop_front();
                if (rsp_data !== exp_word) begin
                    errors = errors + 1;
                    $display("ERROR rsp_data expected %h got %h", exp_word, rsp_data);
                end
            end
        end
    end

    function automatic logic [DATA_W-1:0] range_sum(input logic [ADDR_W-1:0] addr,
                                                    input logic [ADDR_W-1:0] count);
        logic [DATA_W-1:0] s;
        s = '0;
        for (int i = 0; i <= count; i++) begin
            s = s + ref_mem[(int'(addr) + i) % MEM_DEPTH];   // Wraps on overflow.
        end
        return s;
    endfunction

    task automatic send_cmd(input opcode_t op, input logic [ADDR_W-1:0] addr,
                            input logic [ADDR_W-1:0] count, input logic [DATA_W-1:0] data);
        while (host_credits == 0) begin
            @(posedge CK);
            #2;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_count = count;
        cmd_data  = data;
        host_credits = host_credits - 1;
        cmds_sent = cmds_sent + 1;
        case (op)
            OP_WRITE: ref_mem[addr] = data;
            OP_READ:  exp_q.push_back(ref_mem[addr]);
            OP_FILL: begin
                for (int i = 0; i <= count; i++) ref_mem[(int'(addr) + i) % MEM_DEPTH] = data;
            end
            default:  exp_q.push_back(range_sum(addr, count));
        endcase
        @(posedge CK);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_q.size() != 0 || pending != 0) begin
            @(posedge CK);
            #2;
        end
        // A full fifo drains in two cycles per entry.
        while (host_credits != CMD_CREDITS && n < 4 * CMD_CREDITS) begin
            @(posedge CK);
            #2;
            n = n + 1;
        end
        repeat (2) @(posedge CK);
        #2;
    endtask

    task automatic reset_idle();
        rst = 1'b1;
        for (int i = 0; i < 12; i++) begin
            @(posedge CK);
            #2;
            if (i == 4) rst = 1'b0;   // Five rising edges under reset.
            if (rsp_valid !== 1'b0) begin
                errors = errors + 1;
                $display("ERROR rsp_valid expected %h got %h", 1'b0, rsp_valid);
            end
            if (cmd_credit !== 1'b0) begin
                errors = errors + 1;
                $display("ERROR cmd_credit expected %h got %h", 1'b0, cmd_credit);
            end
        end
        @(posedge CK);
        #2;
    endtask

    // Every word gets a value that depends on its whole address.
    task automatic preload();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            send_cmd(OP_WRITE, ADDR_W'(a), '0, {7'h5b, ADDR_W'(a), 7'h1d, ADDR_W'(a)});
        end
        wait_idle();
    endtask

    task automatic write_read();
        logic [ADDR_W-1:0] addrs [12];
        for (int i = 0; i < 12; i++) begin
            addrs[i] = ADDR_W'($urandom % 256);
            send_cmd(OP_WRITE, addrs[i], ADDR_W'($urandom), $urandom);
        end
        for (int i = 0; i < 12; i++) send_cmd(OP_READ, addrs[i], ADDR_W'($urandom), '0);
        send_cmd(OP_READ, ADDR_W'(300 + $urandom % 200), '0, '0);   // Untouched.
        wait_idle();
    endtask

    task automatic fill_sum();
        logic [ADDR_W-1:0] start;
        start = ADDR_W'(470 + $urandom % 20);
        send_cmd(OP_FILL, start, 9'd59, $urandom);   // Wraps past 511.
        send_cmd(OP_SUM, start + 9'd2, 9'd9, '0);
        send_cmd(OP_SUM, 9'd505, 9'd14, '0);
        send_cmd(OP_SUM, start + 9'd5, 9'd0, '0);
        send_cmd(OP_SUM, start + 9'd50, 9'd30, '0);  // Runs out of the fill.
        wait_idle();
    endtask

    task automatic cmd_credit_flow();
        logic [ADDR_W-1:0] a;
        for (int b = 0; b < 3; b++) begin
            a = ADDR_W'($urandom);
            send_cmd(OP_WRITE, a, '0, $urandom);
            send_cmd(OP_WRITE, a + 9'd1, '0, $urandom);
            send_cmd(OP_READ, a + 9'd1, '0, '0);
            send_cmd(OP_READ, a, '0, '0);
        end
        wait_idle();
        if (host_credits != CMD_CREDITS) begin
            errors = errors + 1;
            $display("ERROR host_credits expected %h got %h", CMD_CREDITS, host_credits);
        end
    endtask

    task automatic rsp_credit_flow();
        int base;
        base = rsp_count;
        hold_rsp = 1'b1;
        for (int i = 0; i < 5; i++) send_cmd(OP_READ, ADDR_W'($urandom), '0, '0);
        while (rsp_count - base < 2) begin
            @(posedge CK);
            #2;
        end
        repeat (20) @(posedge CK);   // Engine must stay stalled.
        #2;
        if (rsp_count - base != 2) begin
            errors = errors + 1;
            $display("%0d responses seen with two credits", rsp_count - base);
        end
        hold_rsp = 1'b0;
        wait_idle();
    endtask

    initial begin
        void'($urandom(32'h79ed73e9));
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = OP_WRITE;
        cmd_addr   = '0;
        cmd_count  = '0;
        cmd_data   = '0;
        rsp_credit = 1'b0;
        reset_idle();
        preload();
        write_read();
        fill_sum();
        cmd_credit_flow();
        rsp_credit_flow();
        $display("Errors: %0d, cycles: %0d, commands: %0d, responses: %0d",
                 errors, cycles, cmds_sent, rsp_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/mem_pkg.sv
rtl/flow_pkg.sv
rtl/sram512x32.sv
rtl/cmd_fifo.sv
rtl/burst_gen.sv
rtl/read_accum.sv
rtl/mem_ctrl.sv
rtl/mem_engine_top.sv
sim/tb_mem_engine.sv
